/* src/fb_pkg.sv */
`default_nettype none

package fb_pkg;

    // external SRAM is 1M x 16
    localparam int SRAM_ADDR_W = 20;
    localparam int SRAM_DATA_W = 16;

    // red in the top byte
    typedef logic [23:0] color_t;

    // row * visible width + column
    typedef logic [18:0] pixel_id_t;

    // one queued pixel write
    typedef struct packed {
        pixel_id_t pixel_id;
        color_t    color;
    } pixel_buffer_entry_t;

endpackage : fb_pkg

`default_nettype wire

/* src/vga_pkg.sv */
`default_nettype none

package vga_pkg;

    // 640x480 at 60 Hz, horizontal values in pixel times
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;

    // vertical values in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;

    // each stripe colour covers 1 << STRIPE_SHIFT columns
    localparam int STRIPE_SHIFT = 3;

endpackage : vga_pkg

`default_nettype wire

/* src/sram_port_if.sv */
`default_nettype none

interface sram_port_if;

    logic [fb_pkg::SRAM_ADDR_W-1:0] addr;
    logic [fb_pkg::SRAM_DATA_W-1:0] wdata;
    logic [fb_pkg::SRAM_DATA_W-1:0] rdata;
    // byte enables, active high
    logic                           ub;
    logic                           lb;
    // access request, active low
    logic                           strobe_b;

    modport client (
        output addr, wdata, ub, lb, strobe_b,
        input  rdata
    );

    modport mux (
        input  addr, wdata, ub, lb, strobe_b,
        output rdata
    );

endinterface : sram_port_if

`default_nettype wire

/* src/pixel_buffer.sv */
`default_nettype none

module pixel_buffer #(
    parameter  int PB_DEPTH = 8,
    localparam int PTR_W    = $clog2(PB_DEPTH),
    localparam int CNT_W    = $clog2(PB_DEPTH + 1)
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              we,
    input  wire fb_pkg::pixel_buffer_entry_t wdata,
    output logic                             full,
    input  wire                              re,
    output logic                             empty,
    output fb_pkg::pixel_buffer_entry_t      rdata
);

    fb_pkg::pixel_buffer_entry_t mem [PB_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_wr;
    logic do_rd;

    assign full  = (count == CNT_W'(PB_DEPTH));
    assign empty = (count == '0);
    assign do_wr = we & ~full;
    assign do_rd = re & ~empty;

    // show-ahead, head entry always visible
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(PB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(PB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : pixel_buffer

`default_nettype wire

/* src/pixel_dispatch.sv */
`default_nettype none

module pixel_dispatch #(
    parameter  int N_LANES = 4,
    localparam int LANE_W  = $clog2(N_LANES)
) (
    input  wire                         pix_we,
    input  wire fb_pkg::pixel_id_t      pix_id,
    input  wire fb_pkg::color_t         pix_color,
    output logic                        pix_full,
    output logic [N_LANES-1:0]          lane_we,
    output fb_pkg::pixel_buffer_entry_t lane_entry [N_LANES],
    input  wire [N_LANES-1:0]           lane_full
);

    logic [LANE_W-1:0] lane;
    fb_pkg::pixel_buffer_entry_t entry;

    // low id bits pick the lane, so one pixel always lands in the same FIFO
    assign lane  = pix_id[LANE_W-1:0];
    assign entry = '{pixel_id: pix_id, color: pix_color};

    assign pix_full = lane_full[lane];

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            lane_we[i]    = pix_we && (lane == LANE_W'(i)) && !lane_full[i];
            lane_entry[i] = entry;
        end
    end

endmodule : pixel_dispatch

`default_nettype wire

/* src/pb_arbiter.sv */
`default_nettype none

module pb_arbiter #(
    parameter  int N_LANES = 4,
    localparam int LANE_W  = $clog2(N_LANES)
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire [N_LANES-1:0]                lane_empty,
    input  wire fb_pkg::pixel_buffer_entry_t lane_data [N_LANES],
    output logic [N_LANES-1:0]               lane_re,
    output logic                             pb_empty,
    output fb_pkg::pixel_buffer_entry_t      pb_data,
    input  wire                              pb_re
);

    logic [LANE_W-1:0] ptr;
    logic [LANE_W-1:0] grant;

    // scan from the far end so the nearest non-empty lane wins
    always_comb begin
        grant = ptr;
        for (int k = N_LANES - 1; k >= 0; k--) begin
            if (!lane_empty[ptr + LANE_W'(k)]) begin
                grant = ptr + LANE_W'(k);
            end
        end
    end

    assign pb_empty = lane_empty[grant];
    assign pb_data  = lane_data[grant];

    always_comb begin
        lane_re        = '0;
        lane_re[grant] = pb_re;
    end

    // park on the granted lane until its entry is popped
    // keeps the entry stable between the two SRAM writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (pb_re) begin
            ptr <= grant + 1'b1;
        end else if (!pb_empty) begin
            ptr <= grant;
        end
    end

endmodule : pb_arbiter

`default_nettype wire

/* src/fbh_writer.sv */
`default_nettype none

module fbh_writer (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              pb_empty,
    input  wire fb_pkg::pixel_buffer_entry_t pb_data,
    input  wire                              reader_busy,
    output logic                             pb_re,
    sram_port_if.client                      port
);

    localparam int AW = fb_pkg::SRAM_ADDR_W;

    logic first_write;
    logic strobe;
    logic odd;
    fb_pkg::color_t color;
    logic [AW-1:0] base_addr;

    assign color = pb_data.color;
    assign odd   = pb_data.pixel_id[0];

    // byte 3p lives in word p + p/2
    assign base_addr = AW'(pb_data.pixel_id) + AW'(pb_data.pixel_id >> 1);

    // only cycles the reader leaves free
    assign strobe        = ~pb_empty & ~reader_busy;
    assign pb_re         = strobe & ~first_write;
    assign port.strobe_b = ~strobe;
    assign port.addr     = first_write ? base_addr : base_addr + 1'b1;

    // even pixel: full word then high byte; odd pixel: low byte then full word
    assign port.ub = ~(first_write & odd);
    assign port.lb = first_write | odd;

    always_comb begin
        case ({first_write, odd})
            2'b10:   port.wdata = color[23:8];
            2'b11:   port.wdata = {8'h00, color[23:16]};
            2'b00:   port.wdata = {color[7:0], 8'h00};
            default: port.wdata = color[15:0];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_write <= 1'b1;
        end else if (strobe) begin
            first_write <= ~first_write;
        end
    end

endmodule : fbh_writer

`default_nettype wire

/* src/vga_timing.sv */
`default_nettype none

module vga_timing #(
    parameter  int H_ACTIVE = vga_pkg::H_ACTIVE,
    parameter  int H_FRONT  = vga_pkg::H_FRONT,
    parameter  int H_SYNC   = vga_pkg::H_SYNC,
    parameter  int H_BACK   = vga_pkg::H_BACK,
    parameter  int V_ACTIVE = vga_pkg::V_ACTIVE,
    parameter  int V_FRONT  = vga_pkg::V_FRONT,
    parameter  int V_SYNC   = vga_pkg::V_SYNC,
    parameter  int V_BACK   = vga_pkg::V_BACK,
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK,
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK,
    localparam int H_W      = $clog2(H_TOTAL),
    localparam int V_W      = $clog2(V_TOTAL)
) (
    input  wire            clk,
    input  wire            rst_n,
    output logic           pix_en,
    output logic [H_W-1:0] h_cnt,
    output logic [V_W-1:0] v_cnt,
    output logic           active,
    output logic           frame_start,
    output logic           hsync,
    output logic           vsync
);

    // start in the first blank line, so nothing is fetched right after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_en <= 1'b0;
            h_cnt  <= '0;
            v_cnt  <= V_W'(V_ACTIVE);
        end else begin
            pix_en <= ~pix_en;
            if (pix_en) begin
                if (h_cnt == H_W'(H_TOTAL - 1)) begin
                    h_cnt <= '0;
                    v_cnt <= (v_cnt == V_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
                end else begin
                    h_cnt <= h_cnt + 1'b1;
                end
            end
        end
    end

    assign active = (h_cnt < H_W'(H_ACTIVE)) && (v_cnt < V_W'(V_ACTIVE));

    // sync pulses are active low
    assign hsync = !((h_cnt >= H_W'(H_ACTIVE + H_FRONT)) &&
                     (h_cnt < H_W'(H_ACTIVE + H_FRONT + H_SYNC)));
    assign vsync = !((v_cnt >= V_W'(V_ACTIVE + V_FRONT)) &&
                     (v_cnt < V_W'(V_ACTIVE + V_FRONT + V_SYNC)));

    // first pixel time of the last blank line
    assign frame_start = pix_en && (h_cnt == '0) && (v_cnt == V_W'(V_TOTAL - 1));

endmodule : vga_timing

`default_nettype wire

/* src/fbh_reader.sv */
`default_nettype none

module fbh_reader #(
    parameter  int H_ACTIVE = vga_pkg::H_ACTIVE,
    parameter  int H_FRONT  = vga_pkg::H_FRONT,
    parameter  int H_SYNC   = vga_pkg::H_SYNC,
    parameter  int H_BACK   = vga_pkg::H_BACK,
    parameter  int V_ACTIVE = vga_pkg::V_ACTIVE,
    parameter  int V_FRONT  = vga_pkg::V_FRONT,
    parameter  int V_SYNC   = vga_pkg::V_SYNC,
    parameter  int V_BACK   = vga_pkg::V_BACK,
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK,
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK,
    localparam int H_W      = $clog2(H_TOTAL),
    localparam int V_W      = $clog2(V_TOTAL)
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            stripes_sel,
    sram_port_if.client    port,
    output logic           hs,
    output logic           vs,
    output logic           vga_clk,
    output logic           vga_blank,
    output fb_pkg::color_t vga_rgb
);

    logic pix_en;
    logic active;
    logic frame_start;
    logic hsync;
    logic vsync;
    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic line_fetch;
    logic edge_fetch;
    logic fetch;
    logic [2:0] ring;
    logic [fb_pkg::SRAM_ADDR_W-1:0] addr_cnt;
    logic [fb_pkg::SRAM_DATA_W-1:0] a_q;
    logic [fb_pkg::SRAM_DATA_W-1:0] b_q;
    logic [fb_pkg::SRAM_DATA_W-1:0] c_q;
    logic [2:0] stripe;
    fb_pkg::color_t pixel_q;
    fb_pkg::color_t stripes_rgb;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) i_timing (
        .clk, .rst_n, .pix_en, .h_cnt, .v_cnt, .active, .frame_start, .hsync, .vsync
    );

    // words of pair k are read while pair k-1 is shown (H_TOTAL must be even)
    assign line_fetch = (h_cnt < H_W'(H_ACTIVE - 2)) && (v_cnt < V_W'(V_ACTIVE));
    // pair 0 comes from the last two pixel times of the line before
    assign edge_fetch = (h_cnt >= H_W'(H_TOTAL - 2)) &&
                        ((v_cnt == V_W'(V_TOTAL - 1)) || (v_cnt < V_W'(V_ACTIVE - 1)));
    // fourth clk of each pair goes to the writer
    assign fetch = (line_fetch || edge_fetch) && !(h_cnt[0] && pix_en);

    assign port.strobe_b = ~fetch;
    assign port.addr     = addr_cnt;
    assign port.wdata    = '0;
    assign port.ub       = 1'b1;
    assign port.lb       = 1'b1;

    // ring bit 0 loads A, bit 1 B, bit 2 C
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_cnt <= '0;
            ring     <= 3'b001;
        end else if (frame_start) begin
            addr_cnt <= '0;
            ring     <= 3'b001;
        end else if (fetch) begin
            addr_cnt <= addr_cnt + 1'b1;
            ring     <= {ring[1:0], ring[2]};
        end
    end

    // A = {R0,G0}, B = {B0,R1}, C = {G1,B1}
    always_ff @(posedge clk) begin
        if (fetch && ring[0]) begin
            a_q <= port.rdata;
        end
        if (fetch && ring[1]) begin
            b_q <= port.rdata;
        end
        if (fetch && ring[2]) begin
            c_q <= port.rdata;
        end
        // odd column now, so the next one is the even pixel of a pair
        if (pix_en) begin
            pixel_q <= h_cnt[0] ? {a_q, b_q[15:8]} : {b_q[7:0], c_q};
        end
    end

    assign stripe      = 3'(h_cnt >> vga_pkg::STRIPE_SHIFT);
    assign stripes_rgb = {stripe[2], 7'b0, stripe[1], 7'b0, stripe[0], 7'b0};

    // everything leaves one pixel time after its column
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs        <= 1'b1;
            vs        <= 1'b1;
            vga_blank <= 1'b1;
            vga_rgb   <= '0;
        end else if (pix_en) begin
            hs        <= hsync;
            vs        <= vsync;
            vga_blank <= ~active;
            vga_rgb   <= stripes_sel ? stripes_rgb : pixel_q;
        end
    end

    // rises mid-way through each output pixel
    assign vga_clk = pix_en;

endmodule : fbh_reader

`default_nettype wire

/* src/frame_buffer_handler.sv */
`default_nettype none

module frame_buffer_handler #(
    parameter int N_LANES  = 4,
    parameter int PB_DEPTH = 8,
    parameter int H_ACTIVE = vga_pkg::H_ACTIVE,
    parameter int H_FRONT  = vga_pkg::H_FRONT,
    parameter int H_SYNC   = vga_pkg::H_SYNC,
    parameter int H_BACK   = vga_pkg::H_BACK,
    parameter int V_ACTIVE = vga_pkg::V_ACTIVE,
    parameter int V_FRONT  = vga_pkg::V_FRONT,
    parameter int V_SYNC   = vga_pkg::V_SYNC,
    parameter int V_BACK   = vga_pkg::V_BACK
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             pix_we,
    input  wire fb_pkg::pixel_id_t          pix_id,
    input  wire fb_pkg::color_t             pix_color,
    input  wire                             stripes_sel,
    output logic                            pix_full,
    output logic [fb_pkg::SRAM_ADDR_W-1:0]  sram_addr,
    output logic                            sram_ub_b,
    output logic                            sram_lb_b,
    output logic                            sram_we_b,
    output logic                            sram_oe_b,
    output logic                            sram_ce_b,
    inout  wire  [fb_pkg::SRAM_DATA_W-1:0]  sram_io,
    output logic                            hs,
    output logic                            vs,
    output logic                            vga_clk,
    output logic                            vga_blank,
    output fb_pkg::color_t                  vga_rgb
);

    logic [N_LANES-1:0] lane_we;
    logic [N_LANES-1:0] lane_full;
    logic [N_LANES-1:0] lane_empty;
    logic [N_LANES-1:0] lane_re;
    fb_pkg::pixel_buffer_entry_t lane_entry [N_LANES];
    fb_pkg::pixel_buffer_entry_t lane_data [N_LANES];
    fb_pkg::pixel_buffer_entry_t pb_data;
    logic pb_empty;
    logic pb_re;
    logic reader_busy;
    logic rd_sel;

    sram_port_if wr_port ();
    sram_port_if rd_port ();

    pixel_dispatch #(.N_LANES(N_LANES)) i_dispatch (
        .pix_we, .pix_id, .pix_color, .pix_full, .lane_we, .lane_entry, .lane_full
    );

    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        pixel_buffer #(.PB_DEPTH(PB_DEPTH)) i_buffer (
            .clk, .rst_n,
            .we(lane_we[i]), .wdata(lane_entry[i]), .full(lane_full[i]),
            .re(lane_re[i]), .empty(lane_empty[i]), .rdata(lane_data[i])
        );
    end

    pb_arbiter #(.N_LANES(N_LANES)) i_arbiter (
        .clk, .rst_n, .lane_empty, .lane_data, .lane_re, .pb_empty, .pb_data, .pb_re
    );

    fbh_writer i_writer (
        .clk, .rst_n, .pb_empty, .pb_data, .reader_busy, .pb_re, .port(wr_port)
    );

    fbh_reader #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) i_reader (
        .clk, .rst_n, .stripes_sel, .port(rd_port),
        .hs, .vs, .vga_clk, .vga_blank, .vga_rgb
    );

    // reader always wins the pins
    assign rd_sel      = ~rd_port.strobe_b;
    assign reader_busy = rd_sel;

    assign sram_ce_b = 1'b0;
    assign sram_oe_b = rd_port.strobe_b;
    assign sram_we_b = rd_sel | wr_port.strobe_b;
    assign sram_addr = rd_sel ? rd_port.addr : wr_port.addr;
    assign sram_ub_b = rd_sel ? ~rd_port.ub : ~wr_port.ub;
    assign sram_lb_b = rd_sel ? ~rd_port.lb : ~wr_port.lb;

    assign sram_io = ~sram_we_b ? wr_port.wdata : 'z;

    assign rd_port.rdata = sram_io;
    assign wr_port.rdata = sram_io;

endmodule : frame_buffer_handler

`default_nettype wire

/* test/sram_model.sv */
`default_nettype none

module sram_model #(
    parameter int ADDR_W = 20,
    parameter int DATA_W = 16,
    parameter int DEPTH  = 1024
) (
    input  wire [ADDR_W-1:0] addr,
    input  wire              ub_b,
    input  wire              lb_b,
    input  wire              we_b,
    input  wire              oe_b,
    input  wire              ce_b,
    inout  wire [DATA_W-1:0] io
);

    localparam int HALF  = DATA_W / 2;
    localparam int IDX_W = $clog2(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [IDX_W-1:0]  idx;
    logic              in_range;
    logic [DATA_W-1:0] rd_word;

    assign idx      = addr[IDX_W-1:0];
    assign in_range = (int'(addr) < DEPTH);
    assign rd_word  = in_range ? mem[idx] : '0;

    // read data only while output enabled and not writing
    assign io = (!ce_b && !oe_b && we_b) ? rd_word : 'z;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
        forever begin
            @(addr or io or ub_b or lb_b or we_b or ce_b);
            // pins settle within the time step of the clock edge
            #1;
            if (!ce_b && !we_b && in_range) begin
                if (!ub_b) begin
                    mem[idx][DATA_W-1:HALF] = io[DATA_W-1:HALF];
                end
                if (!lb_b) begin
                    mem[idx][HALF-1:0] = io[HALF-1:0];
                end
            end
        end
    end

endmodule : sram_model

`default_nettype wire

/* test/tb_frame_buffer_handler.sv */
`default_nettype none

module tb_frame_buffer_handler;

    localparam int H_ACTIVE     = 32;
    localparam int H_FRONT      = 4;
    localparam int H_SYNC       = 4;
    localparam int H_BACK       = 4;
    localparam int V_ACTIVE     = 8;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 1;
    localparam int V_BACK       = 1;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = 2 * H_TOTAL * V_TOTAL;
    localparam int N_PIX        = H_ACTIVE * V_ACTIVE;
    localparam int N_LANES      = 4;
    localparam int PB_DEPTH     = 8;
    localparam int N_HOT        = 16;
    localparam int N_OVERWRITES = 96;
    localparam int N_BURST      = N_PIX / N_LANES;
    localparam int N_WRITES     = N_PIX + N_OVERWRITES + N_BURST;
    // three checks of two idle frames each plus alignment, stripes and sync with margin
    localparam int N_FRAMES     = 24;
    localparam int CYCLE_LIMIT  = N_WRITES * 2 * 3 + N_FRAMES * FRAME_CYCLES;
    localparam logic [31:0] SEED = 32'h814b_15c2;

    logic clk = 1'b0;
    logic rst_n;
    logic pix_we;
    fb_pkg::pixel_id_t pix_id;
    fb_pkg::color_t pix_color;
    logic stripes_sel;
    logic pix_full;
    logic [fb_pkg::SRAM_ADDR_W-1:0] sram_addr;
    logic sram_ub_b;
    logic sram_lb_b;
    logic sram_we_b;
    logic sram_oe_b;
    logic sram_ce_b;
    wire [fb_pkg::SRAM_DATA_W-1:0] sram_io;
    logic hs;
    logic vs;
    logic vga_clk;
    logic vga_blank;
    fb_pkg::color_t vga_rgb;

    // expected frame contents by pixel id
    fb_pkg::color_t model_mem [N_PIX];
    int unsigned cycle_cnt = 0;

    frame_buffer_handler #(
        .N_LANES(N_LANES), .PB_DEPTH(PB_DEPTH),
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) i_dut (
        .clk, .rst_n, .pix_we, .pix_id, .pix_color, .stripes_sel, .pix_full,
        .sram_addr, .sram_ub_b, .sram_lb_b, .sram_we_b, .sram_oe_b, .sram_ce_b, .sram_io,
        .hs, .vs, .vga_clk, .vga_blank, .vga_rgb
    );

    sram_model #(
        .ADDR_W(fb_pkg::SRAM_ADDR_W), .DATA_W(fb_pkg::SRAM_DATA_W), .DEPTH(1024)
    ) i_sram (
        .addr(sram_addr), .ub_b(sram_ub_b), .lb_b(sram_lb_b), .we_b(sram_we_b),
        .oe_b(sram_oe_b), .ce_b(sram_ce_b), .io(sram_io)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == 32'(CYCLE_LIMIT)) begin
            $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic idle_cycles(input int n);
        pix_we = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    // called at a falling edge, returns at the falling edge after the write
    task automatic write_pixel(input int id, input fb_pkg::color_t color);
        // pix_full follows the lane of the id already on the pins
        if (pix_id != fb_pkg::pixel_id_t'(id)) begin
            pix_we = 1'b0;
            pix_id = fb_pkg::pixel_id_t'(id);
            @(negedge clk);
        end
        while (pix_full) begin
            pix_we = 1'b0;
            @(negedge clk);
        end
        pix_we        = 1'b1;
        pix_color     = color;
        model_mem[id] = color;
        @(negedge clk);
        pix_we = 1'b0;
    endtask

    task automatic wait_vs_end();
        while (vs) @(negedge clk);
        while (!vs) @(negedge clk);
    endtask

    function automatic fb_pkg::color_t expected_pixel(input int idx, input logic stripes);
        int stripe_idx;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        // stripe number of the column, its three low bits light the channel MSBs
        stripe_idx = (idx % H_ACTIVE) / (1 << vga_pkg::STRIPE_SHIFT);
        red        = ((stripe_idx / 4) % 2 == 1) ? 8'h80 : 8'h00;
        green      = ((stripe_idx / 2) % 2 == 1) ? 8'h80 : 8'h00;
        blue       = (stripe_idx % 2 == 1) ? 8'h80 : 8'h00;
        if (stripes) begin
            return {red, green, blue};
        end else begin
            return model_mem[idx];
        end
    endfunction

    // one sample per pixel time in raster order while blank is low
    task automatic check_frame(input logic stripes);
        int idx;
        idx = 0;
        wait_vs_end();
        while (idx < N_PIX) begin
            @(negedge clk);
            if (vga_clk && !vga_blank) begin
                check_value($sformatf("pixel %0d", idx), 32'(vga_rgb),
                            32'(expected_pixel(idx, stripes)));
                idx++;
            end
        end
    endtask

    task automatic check_sync_counts();
        int hs_pulses;
        int vs_pulses;
        int lines;
        int run;
        logic prev_hs;
        logic prev_vs;
        hs_pulses = 0;
        vs_pulses = 0;
        lines     = 0;
        run       = 0;
        // exactly one frame period of samples after a vs falling edge
        while (!vs) @(negedge clk);
        while (vs) @(negedge clk);
        prev_hs = hs;
        prev_vs = vs;
        repeat (FRAME_CYCLES) begin
            @(negedge clk);
            if (prev_hs && !hs) begin
                hs_pulses++;
            end
            if (prev_vs && !vs) begin
                vs_pulses++;
            end
            if (vga_clk && !vga_blank) begin
                run++;
            end else if (vga_clk && run != 0) begin
                check_value("visible pixels in a line", 32'(run), 32'(H_ACTIVE));
                lines++;
                run = 0;
            end
            prev_hs = hs;
            prev_vs = vs;
        end
        check_value("hs pulses per frame", 32'(hs_pulses), 32'(V_TOTAL));
        check_value("vs pulses per frame", 32'(vs_pulses), 32'd1);
        check_value("active lines per frame", 32'(lines), 32'(V_ACTIVE));
    endtask

    initial begin
        int order [N_PIX];
        int hot_ids [N_HOT];
        int cycles;
        int id;
        int j;
        int tmp;
        logic saw_full;
        fb_pkg::color_t color;

        rst_n       = 1'b0;
        pix_we      = 1'b0;
        pix_id      = '0;
        pix_color   = '0;
        stripes_sel = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i < N_PIX; i++) begin
            model_mem[i] = '0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // reset state, then blank through the vertical blank lines
        check_value("hs after reset", 32'(hs), 32'd1);
        check_value("vs after reset", 32'(vs), 32'd1);
        cycles = 0;
        while (vga_blank) begin
            if (cycles < 2 * H_TOTAL - 8) begin
                check_value("pix_full after reset", 32'(pix_full), 32'd0);
                check_value("sram_we_b after reset", 32'(sram_we_b), 32'd1);
                check_value("sram_oe_b after reset", 32'(sram_oe_b), 32'd1);
            end
            @(negedge clk);
            cycles++;
        end
        check_value("blank until the first active line",
                    32'(cycles >= (V_TOTAL - V_ACTIVE) * 2 * H_TOTAL), 32'd1);

        // every pixel once in shuffled order
        for (int i = 0; i < N_PIX; i++) begin
            order[i] = i;
        end
        for (int i = N_PIX - 1; i > 0; i--) begin
            j        = int'($urandom % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < N_PIX; i++) begin
            write_pixel(order[i], fb_pkg::color_t'($urandom));
        end
        idle_cycles(2 * FRAME_CYCLES);
        check_frame(1'b0);

        // repeated writes to a few hot ids
        // the same id twice in a row goes out back-to-back
        for (int i = 0; i < N_HOT; i++) begin
            hot_ids[i] = int'($urandom % N_PIX);
        end
        id = hot_ids[0];
        for (int k = 0; k < N_OVERWRITES; k++) begin
            if ($urandom % 2 == 0) begin
                j  = int'($urandom % N_HOT);
                id = hot_ids[j];
            end
            write_pixel(id, fb_pkg::color_t'($urandom));
            if ($urandom % 4 == 0) begin
                idle_cycles(1 + int'($urandom % 3));
            end
        end
        idle_cycles(2 * FRAME_CYCLES);
        check_frame(1'b0);

        // one write per cycle into lane 0
        // writes made while pix_full is high get dropped
        saw_full = 1'b0;
        pix_we   = 1'b0;
        pix_id   = '0;
        @(negedge clk);
        for (int b = 0; b < N_BURST; b++) begin
            color = fb_pkg::color_t'($urandom);
            if (pix_full) begin
                saw_full = 1'b1;
            end else begin
                model_mem[b * N_LANES] = color;
            end
            pix_we    = 1'b1;
            pix_id    = fb_pkg::pixel_id_t'(b * N_LANES);
            pix_color = color;
            @(negedge clk);
        end
        pix_we = 1'b0;
        check_value("pix_full during a one-lane burst", 32'(saw_full), 32'd1);
        idle_cycles(2 * FRAME_CYCLES);
        check_frame(1'b0);

        stripes_sel = 1'b1;
        check_frame(1'b1);
        stripes_sel = 1'b0;

        check_sync_counts();

        $display("All tests passed");
        $finish;
    end

endmodule : tb_frame_buffer_handler

`default_nettype wire

/* tb.f */
src/fb_pkg.sv
src/vga_pkg.sv
src/sram_port_if.sv
src/pixel_buffer.sv
src/pixel_dispatch.sv
src/pb_arbiter.sv
src/fbh_writer.sv
src/vga_timing.sv
src/fbh_reader.sv
src/frame_buffer_handler.sv
test/sram_model.sv
test/tb_frame_buffer_handler.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_frame_buffer_handler
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, not the simulator exit status
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
